/* include/dispatch_settings.svh */
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Datapath width
`define XLEN 32

// Architectural register index width
`define REG_ADDR_W 5

// Reorder buffer geometry
`define ROB_DEPTH 8

// Tag zero means no producer, tags 1 to 7 name ROB entries
`define ROB_TAG_W 3

`endif

/* verilog/dispatch_pkg.sv */
`include "dispatch_settings.svh"

package dispatch_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // funct3 encoding, sub and sra sit in the unused slt/sltu slots
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sub = 3'b010,
        alu_sra = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // Branch funct3, slt/sltu fill the two free codes
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_slt  = 3'b010,
        cmp_sltu = 3'b011,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        unit_none = 2'd0,
        unit_alu  = 2'd1,
        unit_cmp  = 2'd2,
        unit_lsb  = 2'd3
    } unit_e;

    typedef struct packed {
        logic [`XLEN-1:0]      value;
        logic [`ROB_TAG_W-1:0] tag;
        logic                  ready;
    } operand_t;

    typedef struct packed {
        logic             ready;
        logic [`XLEN-1:0] value;
    } rob_entry_t;

    typedef rob_entry_t [`ROB_DEPTH-1:0] rob_array_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } iq_entry_t;

    typedef struct packed {
        logic [`XLEN-1:0]      rs1_value;
        logic [`ROB_TAG_W-1:0] rs1_tag;
        logic [`XLEN-1:0]      rs2_value;
        logic [`ROB_TAG_W-1:0] rs2_tag;
    } reg_read_t;

    typedef struct packed {
        unit_e                  unit;
        alu_op_e                alu_op;
        cmp_op_e                cmp_op;
        logic                   is_branch;
        logic                   is_store;
        logic [2:0]             mem_funct3;
        logic                   writes_rd;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   uses_rs1;
        logic                   uses_rs2;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        operand_t              src1;
        operand_t              src2;
        logic [`ROB_TAG_W-1:0] rob_tag;
    } alu_issue_t;

    typedef struct packed {
        logic                  valid;
        cmp_op_e               op;
        logic                  is_branch;
        operand_t              src1;
        operand_t              src2;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      b_imm;
        logic [`ROB_TAG_W-1:0] rob_tag;
    } cmp_issue_t;

    typedef struct packed {
        logic                  valid;
        logic                  is_store;
        logic [2:0]            funct3;
        operand_t              base;
        operand_t              data;
        logic [`XLEN-1:0]      offset;
        logic [`ROB_TAG_W-1:0] rob_tag;
    } lsb_issue_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
    } rob_alloc_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`ROB_TAG_W-1:0]  tag;
    } rename_t;

endpackage

/* verilog/inst_decoder.sv */
`include "dispatch_settings.svh"

module inst_decoder (
    input  dispatch_pkg::iq_entry_t iq_entry_i,
    output dispatch_pkg::decoded_t  dec_o
);

    logic [31:0]      instr;
    logic [2:0]       funct3;
    logic             funct7_b5;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] shamt;
    dispatch_pkg::opcode_e opcode;

    assign instr     = iq_entry_i.instr;
    assign opcode    = dispatch_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, instr[24:20]}; // funct7 bits stripped off

    always_comb begin
        dec_o            = '0;
        dec_o.unit       = dispatch_pkg::unit_none;
        dec_o.alu_op     = dispatch_pkg::alu_add;
        dec_o.cmp_op     = dispatch_pkg::cmp_beq;
        dec_o.mem_funct3 = funct3;
        dec_o.rd         = instr[11:7];
        dec_o.imm        = i_imm;
        dec_o.pc         = iq_entry_i.pc;
        dec_o.opcode     = opcode;

        case (opcode)
            dispatch_pkg::op_lui, dispatch_pkg::op_auipc: begin
                dec_o.unit      = dispatch_pkg::unit_alu;
                dec_o.writes_rd = 1'b1;
                dec_o.imm       = u_imm;
            end

            dispatch_pkg::op_jal: dec_o.imm = j_imm; // Not issued here

            dispatch_pkg::op_br: begin
                dec_o.unit      = dispatch_pkg::unit_cmp;
                dec_o.cmp_op    = dispatch_pkg::cmp_op_e'(funct3);
                dec_o.is_branch = 1'b1;
                dec_o.uses_rs1  = 1'b1;
                dec_o.uses_rs2  = 1'b1;
                dec_o.imm       = b_imm;
            end

            dispatch_pkg::op_load: begin
                dec_o.unit      = dispatch_pkg::unit_lsb;
                dec_o.writes_rd = 1'b1;
                dec_o.uses_rs1  = 1'b1;
            end

            dispatch_pkg::op_store: begin
                dec_o.unit     = dispatch_pkg::unit_lsb;
                dec_o.is_store = 1'b1;
                dec_o.uses_rs1 = 1'b1;
                dec_o.uses_rs2 = 1'b1;
                dec_o.imm      = s_imm;
            end

            dispatch_pkg::op_imm, dispatch_pkg::op_reg: begin
                dec_o.writes_rd = 1'b1;
                dec_o.uses_rs1  = 1'b1;
                dec_o.uses_rs2  = (opcode == dispatch_pkg::op_reg);
                dec_o.unit      = dispatch_pkg::unit_alu;
                case (funct3)
                    3'b000: begin
                        // Only the register form has SUB
                        if (opcode == dispatch_pkg::op_reg && funct7_b5)
                            dec_o.alu_op = dispatch_pkg::alu_sub;
                        else
                            dec_o.alu_op = dispatch_pkg::alu_add;
                    end
                    3'b010: begin
                        dec_o.unit   = dispatch_pkg::unit_cmp;
                        dec_o.cmp_op = dispatch_pkg::cmp_slt;
                    end
                    3'b011: begin
                        dec_o.unit   = dispatch_pkg::unit_cmp;
                        dec_o.cmp_op = dispatch_pkg::cmp_sltu;
                    end
                    3'b101: begin
                        dec_o.alu_op = funct7_b5 ? dispatch_pkg::alu_sra : dispatch_pkg::alu_srl;
                        if (opcode == dispatch_pkg::op_imm)
                            dec_o.imm = shamt;
                    end
                    3'b001: begin
                        dec_o.alu_op = dispatch_pkg::alu_sll;
                        if (opcode == dispatch_pkg::op_imm)
                            dec_o.imm = shamt;
                    end
                    default: dec_o.alu_op = dispatch_pkg::alu_op_e'(funct3); // xor, or, and
                endcase
            end

            default: ; // JALR and unknown words stay unit none
        endcase
    end

endmodule

/* verilog/operand_bypass.sv */
`include "dispatch_settings.svh"

module operand_bypass (
    input  dispatch_pkg::reg_read_t  reg_read_i,
    input  dispatch_pkg::rob_array_t rob_i,
    output dispatch_pkg::operand_t   src1_o,
    output dispatch_pkg::operand_t   src2_o
);

    logic fwd1;
    logic fwd2;

    function automatic dispatch_pkg::operand_t pick(
        input logic                  fwd,
        input logic [`XLEN-1:0]      rob_value,
        input logic [`XLEN-1:0]      reg_value,
        input logic [`ROB_TAG_W-1:0] reg_tag
    );
        dispatch_pkg::operand_t op;
        if (fwd) begin
            op.value = rob_value;
            op.tag   = '0;
            op.ready = 1'b1;
        end else begin
            op.value = reg_value;
            op.tag   = reg_tag;
            op.ready = (reg_tag == '0); // Still waiting on a producer
        end
        return op;
    endfunction

    // Producer already completed in the ROB
    assign fwd1 = (reg_read_i.rs1_tag != '0) && rob_i[reg_read_i.rs1_tag].ready;
    assign fwd2 = (reg_read_i.rs2_tag != '0) && rob_i[reg_read_i.rs2_tag].ready;

    assign src1_o = pick(fwd1, rob_i[reg_read_i.rs1_tag].value, reg_read_i.rs1_value,
                         reg_read_i.rs1_tag);
    assign src2_o = pick(fwd2, rob_i[reg_read_i.rs2_tag].value, reg_read_i.rs2_value,
                         reg_read_i.rs2_tag);

    always_comb begin
        if (fwd1)
            assert (src1_o.tag == '0 && src1_o.ready) else $error("rs1 forward left tagged");
        if (fwd2)
            assert (src2_o.tag == '0 && src2_o.ready) else $error("rs2 forward left tagged");
    end

endmodule

/* verilog/issue_stage.sv */
`include "dispatch_settings.svh"

module issue_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        iq_empty_i,
    input  dispatch_pkg::decoded_t      dec_i,
    input  dispatch_pkg::operand_t      src1_i,
    input  dispatch_pkg::operand_t      src2_i,
    input  logic [`ROB_TAG_W-1:0]       rob_free_tag_i,
    input  logic                        rob_full_i,
    input  logic                        alu_full_i,
    input  logic                        cmp_full_i,
    input  logic                        lsb_full_i,
    output logic                        iq_read_o,
    output dispatch_pkg::alu_issue_t    alu_issue_o,
    output dispatch_pkg::cmp_issue_t    cmp_issue_o,
    output dispatch_pkg::lsb_issue_t    lsb_issue_o,
    output dispatch_pkg::rob_alloc_t    rob_alloc_o,
    output dispatch_pkg::rename_t       rename_o
);

    logic unit_full;
    logic skip;
    logic accept;
    logic issue;
    dispatch_pkg::operand_t   op1;
    dispatch_pkg::operand_t   op2;
    dispatch_pkg::alu_issue_t alu_d;
    dispatch_pkg::alu_issue_t alu_q;
    dispatch_pkg::cmp_issue_t cmp_d;
    dispatch_pkg::cmp_issue_t cmp_q;
    dispatch_pkg::lsb_issue_t lsb_d;
    dispatch_pkg::lsb_issue_t lsb_q;
    dispatch_pkg::rob_alloc_t alloc_d;
    dispatch_pkg::rob_alloc_t alloc_q;
    dispatch_pkg::rename_t    ren_d;
    dispatch_pkg::rename_t    ren_q;
    logic alu_v_q;
    logic cmp_v_q;
    logic lsb_v_q;
    logic alloc_v_q;
    logic ren_v_q;

    always_comb begin
        case (dec_i.unit)
            dispatch_pkg::unit_alu: unit_full = alu_full_i;
            dispatch_pkg::unit_cmp: unit_full = cmp_full_i;
            dispatch_pkg::unit_lsb: unit_full = lsb_full_i;
            default:                unit_full = 1'b0;
        endcase
    end

    // Dropped heads need no ROB entry and no unit
    assign skip   = (dec_i.unit == dispatch_pkg::unit_none) || (dec_i.writes_rd && dec_i.rd == '0);
    assign accept = !iq_empty_i && !flush_i &&
                    (skip || (!rob_full_i && rob_free_tag_i != '0 && !unit_full));
    assign issue     = accept && !skip;
    assign iq_read_o = accept;

    always_comb begin
        op1 = src1_i;
        if (!dec_i.uses_rs1)
            op1.value = (dec_i.opcode == dispatch_pkg::op_auipc) ? dec_i.pc : '0; // AUIPC or LUI
        if (!dec_i.uses_rs1) begin
            op1.tag   = '0;
            op1.ready = 1'b1;
        end
        op2 = src2_i;
        if (!dec_i.uses_rs2)
            op2 = '{value: dec_i.imm, tag: '0, ready: 1'b1};
    end

    always_comb begin
        alu_d.valid   = issue && (dec_i.unit == dispatch_pkg::unit_alu);
        alu_d.op      = dec_i.alu_op;
        alu_d.src1    = op1;
        alu_d.src2    = op2;
        alu_d.rob_tag = rob_free_tag_i;

        cmp_d.valid     = issue && (dec_i.unit == dispatch_pkg::unit_cmp);
        cmp_d.op        = dec_i.cmp_op;
        cmp_d.is_branch = dec_i.is_branch;
        cmp_d.src1      = op1;
        cmp_d.src2      = op2;
        cmp_d.pc        = dec_i.pc;
        cmp_d.b_imm     = dec_i.is_branch ? dec_i.imm : '0;
        cmp_d.rob_tag   = rob_free_tag_i;

        lsb_d.valid    = issue && (dec_i.unit == dispatch_pkg::unit_lsb);
        lsb_d.is_store = dec_i.is_store;
        lsb_d.funct3   = dec_i.mem_funct3;
        lsb_d.base     = op1;
        lsb_d.data     = src2_i;
        if (!dec_i.is_store)
            lsb_d.data = '{value: '0, tag: '0, ready: 1'b1}; // Loads carry no data
        lsb_d.offset   = dec_i.imm;
        lsb_d.rob_tag  = rob_free_tag_i;

        alloc_d.valid  = issue;
        alloc_d.pc     = dec_i.pc;
        alloc_d.opcode = dec_i.opcode;
        alloc_d.rd     = dec_i.writes_rd ? dec_i.rd : '0;

        ren_d.valid = issue && dec_i.writes_rd;
        ren_d.rd    = dec_i.rd;
        ren_d.tag   = rob_free_tag_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_v_q   <= 1'b0;
            cmp_v_q   <= 1'b0;
            lsb_v_q   <= 1'b0;
            alloc_v_q <= 1'b0;
            ren_v_q   <= 1'b0;
        end else begin
            alu_v_q   <= alu_d.valid;
            cmp_v_q   <= cmp_d.valid;
            lsb_v_q   <= lsb_d.valid;
            alloc_v_q <= alloc_d.valid;
            ren_v_q   <= ren_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            alu_q   <= alu_d;
            cmp_q   <= cmp_d;
            lsb_q   <= lsb_d;
            alloc_q <= alloc_d;
            ren_q   <= ren_d;
        end
    end

    always_comb begin
        alu_issue_o       = alu_q;
        alu_issue_o.valid = alu_v_q;
        cmp_issue_o       = cmp_q;
        cmp_issue_o.valid = cmp_v_q;
        lsb_issue_o       = lsb_q;
        lsb_issue_o.valid = lsb_v_q;
        rob_alloc_o       = alloc_q;
        rob_alloc_o.valid = alloc_v_q;
        rename_o          = ren_q;
        rename_o.valid    = ren_v_q;
    end

    a_one_issue: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({alu_issue_o.valid, cmp_issue_o.valid, lsb_issue_o.valid}));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        iq_empty_i |-> !iq_read_o);

    a_alloc_matches: assert property (@(posedge clk) disable iff (!rst_n_i)
        rob_alloc_o.valid == (alu_issue_o.valid | cmp_issue_o.valid | lsb_issue_o.valid));

endmodule

/* verilog/dispatch_top.sv */
`include "dispatch_settings.svh"

module dispatch_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  dispatch_pkg::iq_entry_t     iq_entry_i,
    input  logic                        iq_empty_i,
    output logic                        iq_read_o,
    output logic [`REG_ADDR_W-1:0]      rs1_o,
    output logic [`REG_ADDR_W-1:0]      rs2_o,
    input  dispatch_pkg::reg_read_t     reg_read_i,
    input  dispatch_pkg::rob_array_t    rob_i,
    input  logic [`ROB_TAG_W-1:0]       rob_free_tag_i,
    input  logic                        rob_full_i,
    input  logic                        alu_full_i,
    input  logic                        cmp_full_i,
    input  logic                        lsb_full_i,
    output dispatch_pkg::alu_issue_t    alu_issue_o,
    output dispatch_pkg::cmp_issue_t    cmp_issue_o,
    output dispatch_pkg::lsb_issue_t    lsb_issue_o,
    output dispatch_pkg::rob_alloc_t    rob_alloc_o,
    output dispatch_pkg::rename_t       rename_o
);

    dispatch_pkg::decoded_t dec;
    dispatch_pkg::operand_t src1;
    dispatch_pkg::operand_t src2;

    // Register file read address straight from the queue head
    assign rs1_o = iq_entry_i.instr[19:15];
    assign rs2_o = iq_entry_i.instr[24:20];

    inst_decoder u_decoder (
        .iq_entry_i (iq_entry_i),
        .dec_o      (dec)
    );

    operand_bypass u_bypass (
        .reg_read_i (reg_read_i),
        .rob_i      (rob_i),
        .src1_o     (src1),
        .src2_o     (src2)
    );

    issue_stage u_issue (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iq_empty_i     (iq_empty_i),
        .dec_i          (dec),
        .src1_i         (src1),
        .src2_i         (src2),
        .rob_free_tag_i (rob_free_tag_i),
        .rob_full_i     (rob_full_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .iq_read_o      (iq_read_o),
        .alu_issue_o    (alu_issue_o),
        .cmp_issue_o    (cmp_issue_o),
        .lsb_issue_o    (lsb_issue_o),
        .rob_alloc_o    (rob_alloc_o),
        .rename_o       (rename_o)
    );

endmodule

/* tests/ref_model.sv */
`include "dispatch_settings.svh"

module ref_model (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  dispatch_pkg::iq_entry_t  iq_entry_i,
    input  logic                     iq_empty_i,
    input  dispatch_pkg::reg_read_t  reg_read_i,
    input  dispatch_pkg::rob_array_t rob_i,
    input  logic [`ROB_TAG_W-1:0]    rob_free_tag_i,
    input  logic                     rob_full_i,
    input  logic                     alu_full_i,
    input  logic                     cmp_full_i,
    input  logic                     lsb_full_i,
    input  logic                     iq_read_i,
    input  logic [`REG_ADDR_W-1:0]   rs1_i,
    input  logic [`REG_ADDR_W-1:0]   rs2_i,
    input  dispatch_pkg::alu_issue_t alu_issue_i,
    input  dispatch_pkg::cmp_issue_t cmp_issue_i,
    input  dispatch_pkg::lsb_issue_t lsb_issue_i,
    input  dispatch_pkg::rob_alloc_t rob_alloc_i,
    input  dispatch_pkg::rename_t    rename_i,
    output int                       errors_o
);

    int errors = 0;
    dispatch_pkg::alu_issue_t exp_alu   = '0;
    dispatch_pkg::cmp_issue_t exp_cmp   = '0;
    dispatch_pkg::lsb_issue_t exp_lsb   = '0;
    dispatch_pkg::rob_alloc_t exp_alloc = '0;
    dispatch_pkg::rename_t    exp_ren   = '0;

    assign errors_o = errors;

    task automatic check(input string name, input logic [159:0] exp_val,
                         input logic [159:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
            errors = errors + 1;
        end
    endtask

    // Regfile value, or the ROB result once its producer has completed
    function automatic dispatch_pkg::operand_t read_src(input logic [`ROB_TAG_W-1:0] tag,
                                                        input logic [`XLEN-1:0] value);
        dispatch_pkg::operand_t src;
        src.value = value;
        src.tag   = tag;
        src.ready = (tag == '0);
        if (tag != '0 && rob_i[tag].ready) begin
            src.value = rob_i[tag].value;
            src.tag   = '0;
            src.ready = 1'b1;
        end
        return src;
    endfunction

    function automatic dispatch_pkg::operand_t const_op(input logic [`XLEN-1:0] value);
        dispatch_pkg::operand_t src;
        src.value = value;
        src.tag   = '0;
        src.ready = 1'b1;
        return src;
    endfunction

    always @(negedge clk) begin : model_step
        logic [31:0]            ins;
        logic [2:0]             f3;
        logic [`XLEN-1:0]       imm_i;
        logic [`XLEN-1:0]       imm_s;
        logic [`XLEN-1:0]       imm_b;
        logic [`XLEN-1:0]       imm_u;
        logic                   writes;
        logic                   full;
        logic                   skip;
        logic                   accept;
        logic                   issue;
        dispatch_pkg::unit_e    unit;
        dispatch_pkg::operand_t s1;
        dispatch_pkg::operand_t s2;

        // Registered outputs belong to the previous cycle's inputs
        check("alu_issue valid", 160'(exp_alu.valid), 160'(alu_issue_i.valid));
        if (exp_alu.valid)
            check("alu_issue", 160'(exp_alu), 160'(alu_issue_i));
        check("cmp_issue valid", 160'(exp_cmp.valid), 160'(cmp_issue_i.valid));
        if (exp_cmp.valid)
            check("cmp_issue", 160'(exp_cmp), 160'(cmp_issue_i));
        check("lsb_issue valid", 160'(exp_lsb.valid), 160'(lsb_issue_i.valid));
        if (exp_lsb.valid)
            check("lsb_issue", 160'(exp_lsb), 160'(lsb_issue_i));
        check("rob_alloc valid", 160'(exp_alloc.valid), 160'(rob_alloc_i.valid));
        if (exp_alloc.valid)
            check("rob_alloc", 160'(exp_alloc), 160'(rob_alloc_i));
        check("rename valid", 160'(exp_ren.valid), 160'(rename_i.valid));
        if (exp_ren.valid)
            check("rename", 160'(exp_ren), 160'(rename_i));

        ins   = iq_entry_i.instr;
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        s1    = read_src(reg_read_i.rs1_tag, reg_read_i.rs1_value);
        s2    = read_src(reg_read_i.rs2_tag, reg_read_i.rs2_value);

        check("rs1 address", 160'(ins[19:15]), 160'(rs1_i));
        check("rs2 address", 160'(ins[24:20]), 160'(rs2_i));

        exp_alu   = '0;
        exp_cmp   = '0;
        exp_lsb   = '0;
        exp_alloc = '0;
        exp_ren   = '0;
        unit      = dispatch_pkg::unit_none;
        writes    = 1'b0;
        exp_cmp.pc = iq_entry_i.pc;

        case (ins[6:0])
            7'b0110111, 7'b0010111: begin // LUI, AUIPC
                unit         = dispatch_pkg::unit_alu;
                writes       = 1'b1;
                exp_alu.op   = dispatch_pkg::alu_add;
                exp_alu.src1 = const_op((ins[6:0] == 7'b0010111) ? iq_entry_i.pc : '0);
                exp_alu.src2 = const_op(imm_u);
            end
            7'b0010011, 7'b0110011: begin
                writes = 1'b1;
                if (!ins[5])
                    s2 = const_op((f3[1:0] == 2'b01) ? {27'b0, ins[24:20]} : imm_i); // shamt
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    unit         = dispatch_pkg::unit_cmp;
                    exp_cmp.op   = f3[0] ? dispatch_pkg::cmp_sltu : dispatch_pkg::cmp_slt;
                    exp_cmp.src1 = s1;
                    exp_cmp.src2 = s2;
                end else begin
                    unit         = dispatch_pkg::unit_alu;
                    exp_alu.src1 = s1;
                    exp_alu.src2 = s2;
                    case (f3)
                        3'b000:  exp_alu.op = (ins[5] && ins[30]) ? dispatch_pkg::alu_sub
                                                                  : dispatch_pkg::alu_add;
                        3'b001:  exp_alu.op = dispatch_pkg::alu_sll;
                        3'b100:  exp_alu.op = dispatch_pkg::alu_xor;
                        3'b101:  exp_alu.op = ins[30] ? dispatch_pkg::alu_sra
                                                      : dispatch_pkg::alu_srl;
                        3'b110:  exp_alu.op = dispatch_pkg::alu_or;
                        default: exp_alu.op = dispatch_pkg::alu_and;
                    endcase
                end
            end
            7'b1100011: begin // Branches
                unit              = dispatch_pkg::unit_cmp;
                exp_cmp.is_branch = 1'b1;
                exp_cmp.src1      = s1;
                exp_cmp.src2      = s2;
                exp_cmp.b_imm     = imm_b;
                case (f3)
                    3'b000:  exp_cmp.op = dispatch_pkg::cmp_beq;
                    3'b001:  exp_cmp.op = dispatch_pkg::cmp_bne;
                    3'b100:  exp_cmp.op = dispatch_pkg::cmp_blt;
                    3'b101:  exp_cmp.op = dispatch_pkg::cmp_bge;
                    3'b110:  exp_cmp.op = dispatch_pkg::cmp_bltu;
                    default: exp_cmp.op = dispatch_pkg::cmp_bgeu;
                endcase
            end
            7'b0000011: begin // Loads
                unit           = dispatch_pkg::unit_lsb;
                writes         = 1'b1;
                exp_lsb.funct3 = f3;
                exp_lsb.base   = s1;
                exp_lsb.data   = const_op('0);
                exp_lsb.offset = imm_i;
            end
            7'b0100011: begin // Stores
                unit             = dispatch_pkg::unit_lsb;
                exp_lsb.is_store = 1'b1;
                exp_lsb.funct3   = f3;
                exp_lsb.base     = s1;
                exp_lsb.data     = s2;
                exp_lsb.offset   = imm_s;
            end
            default: ; // JAL, JALR, unknown
        endcase

        case (unit)
            dispatch_pkg::unit_alu: full = alu_full_i;
            dispatch_pkg::unit_cmp: full = cmp_full_i;
            dispatch_pkg::unit_lsb: full = lsb_full_i;
            default:                full = 1'b0;
        endcase

        skip   = (unit == dispatch_pkg::unit_none) || (writes && ins[11:7] == '0);
        accept = !iq_empty_i && !flush_i &&
                 (skip || (!rob_full_i && rob_free_tag_i != '0 && !full));
        issue  = accept && !skip && rst_n_i;
        check("iq_read", 160'(accept), 160'(iq_read_i));

        exp_alu.valid    = issue && (unit == dispatch_pkg::unit_alu);
        exp_cmp.valid    = issue && (unit == dispatch_pkg::unit_cmp);
        exp_lsb.valid    = issue && (unit == dispatch_pkg::unit_lsb);
        exp_alu.rob_tag  = rob_free_tag_i;
        exp_cmp.rob_tag  = rob_free_tag_i;
        exp_lsb.rob_tag  = rob_free_tag_i;
        exp_alloc.valid  = issue;
        exp_alloc.pc     = iq_entry_i.pc;
        exp_alloc.opcode = dispatch_pkg::opcode_e'(ins[6:0]);
        exp_alloc.rd     = writes ? ins[11:7] : '0; // Branches and stores hold no rd
        exp_ren.valid    = issue && writes;
        exp_ren.rd       = ins[11:7];
        exp_ren.tag      = rob_free_tag_i;
    end

endmodule

/* tests/dispatch_tb.sv */
`include "dispatch_settings.svh"

module dispatch_tb;

    localparam int NUM_CYCLES = 4000;
    localparam int CLK_PERIOD = 8;
    localparam int STIM_DELAY = 1;
    localparam int TIMEOUT    = NUM_CYCLES * CLK_PERIOD + 200; // Reset and drain in the margin

    logic                     clk = 1'b0;
    logic                     rst_n_i = 1'b0;
    logic                     flush_i;
    dispatch_pkg::iq_entry_t  iq_entry_i;
    logic                     iq_empty_i;
    logic                     iq_read_o;
    logic [`REG_ADDR_W-1:0]   rs1_o;
    logic [`REG_ADDR_W-1:0]   rs2_o;
    dispatch_pkg::reg_read_t  reg_read_i;
    dispatch_pkg::rob_array_t rob_i;
    logic [`ROB_TAG_W-1:0]    rob_free_tag_i;
    logic                     rob_full_i;
    logic                     alu_full_i;
    logic                     cmp_full_i;
    logic                     lsb_full_i;
    dispatch_pkg::alu_issue_t alu_issue_o;
    dispatch_pkg::cmp_issue_t cmp_issue_o;
    dispatch_pkg::lsb_issue_t lsb_issue_o;
    dispatch_pkg::rob_alloc_t rob_alloc_o;
    dispatch_pkg::rename_t    rename_o;
    int                       seed;
    int                       ref_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dispatch_top UUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iq_entry_i     (iq_entry_i),
        .iq_empty_i     (iq_empty_i),
        .iq_read_o      (iq_read_o),
        .rs1_o          (rs1_o),
        .rs2_o          (rs2_o),
        .reg_read_i     (reg_read_i),
        .rob_i          (rob_i),
        .rob_free_tag_i (rob_free_tag_i),
        .rob_full_i     (rob_full_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .alu_issue_o    (alu_issue_o),
        .cmp_issue_o    (cmp_issue_o),
        .lsb_issue_o    (lsb_issue_o),
        .rob_alloc_o    (rob_alloc_o),
        .rename_o       (rename_o)
    );

    ref_model u_ref (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iq_entry_i     (iq_entry_i),
        .iq_empty_i     (iq_empty_i),
        .reg_read_i     (reg_read_i),
        .rob_i          (rob_i),
        .rob_free_tag_i (rob_free_tag_i),
        .rob_full_i     (rob_full_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .iq_read_i      (iq_read_o),
        .rs1_i          (rs1_o),
        .rs2_i          (rs2_o),
        .alu_issue_i    (alu_issue_o),
        .cmp_issue_i    (cmp_issue_o),
        .lsb_issue_i    (lsb_issue_o),
        .rob_alloc_i    (rob_alloc_o),
        .rename_i       (rename_o),
        .errors_o       (ref_errors)
    );

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic one_in(input int n);
        return (rnd() % n) == 0;
    endfunction

    task automatic draw_instr(output logic [31:0] ins);
        logic [3:0] kind;
        kind = 4'(rnd());
        ins  = rnd();
        case (kind)
            4'd0:              ins[6:0] = 7'b0110111; // LUI
            4'd1:              ins[6:0] = 7'b0010111; // AUIPC
            4'd2, 4'd3, 4'd4:  ins[6:0] = 7'b0010011;
            4'd5, 4'd6: begin
                ins[6:0]   = 7'b0110011;
                ins[31:25] = {1'b0, ins[30], 5'b0};
            end
            4'd7, 4'd8: begin
                ins[6:0] = 7'b1100011;
                if (ins[13])
                    ins[14] = 1'b1; // 010 and 011 are no branches
            end
            4'd9, 4'd10:       ins[6:0] = 7'b0000011;
            4'd11, 4'd12:      ins[6:0] = 7'b0100011;
            4'd13:             ins[6:0] = 7'b1101111; // JAL
            4'd14:             ins[6:0] = 7'b1100111; // JALR
            default:           ins[6:0] = 7'b0001011; // custom-0, not RV32I
        endcase
        if (one_in(6))
            ins[11:7] = '0;
    endtask

    task automatic drive_idle();
        flush_i        = 1'b0;
        iq_entry_i     = '0;
        iq_empty_i     = 1'b1;
        reg_read_i     = '0;
        rob_i          = '0;
        rob_free_tag_i = '0;
        rob_full_i     = 1'b0;
        alu_full_i     = 1'b0;
        cmp_full_i     = 1'b0;
        lsb_full_i     = 1'b0;
    endtask

    task automatic drive_random();
        logic [31:0] ins;
        logic [31:0] r;
        draw_instr(ins);
        iq_entry_i.instr = ins;
        iq_entry_i.pc    = rnd() & 32'hffff_fffc;
        iq_empty_i       = one_in(8);
        flush_i          = one_in(24);
        reg_read_i.rs1_value = rnd();
        reg_read_i.rs2_value = rnd();
        r = rnd();
        reg_read_i.rs1_tag = r[`ROB_TAG_W-1:0];
        reg_read_i.rs2_tag = r[8 +: `ROB_TAG_W];
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            r              = rnd();
            rob_i[k].ready = r[4];
            rob_i[k].value = rnd();
        end
        r = rnd();
        rob_free_tag_i = r[`ROB_TAG_W-1:0]; // Zero about one cycle in eight
        rob_full_i     = one_in(10);
        alu_full_i     = one_in(6);
        cmp_full_i     = one_in(6);
        lsb_full_i     = one_in(6);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed = 73338;
        drive_idle();
        repeat (2) @(posedge clk);
        #STIM_DELAY rst_n_i = 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            #STIM_DELAY drive_random();
        end
        @(posedge clk);
        #STIM_DELAY drive_idle();
        repeat (2) @(posedge clk); // Last issue gets checked
        #STIM_DELAY;
        $display("Run done: %0d stimulus cycles, %0d errors", NUM_CYCLES, ref_errors);
        if (ref_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
verilog/dispatch_pkg.sv
verilog/inst_decoder.sv
verilog/operand_bypass.sv
verilog/issue_stage.sv
verilog/dispatch_top.sv
tests/ref_model.sv
tests/dispatch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dispatch_sim

rm -rf obj_dir

verilator --binary --timing --assert -f build.f --top-module dispatch_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result comes from the log only
if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
